//--- compile.f
+incdir+include
logic/fpFormatPkg.sv
logic/mulPipePkg.sv
logic/operandUnpack.sv
logic/karatsubaCore.sv
logic/significandMul.sv
logic/productRound.sv
logic/fpMulTop.sv
tb/tbClockGen.sv
tb/fpMulTb.sv

//--- include/fpmul_consts.svh
// Field widths and fixed constants of the single-precision multiply pipeline
// Included by the packages and by every stage that sizes its datapath
`ifndef FPMUL_CONSTS_SVH
`define FPMUL_CONSTS_SVH

// IEEE-754 single-precision fields
`define FPMUL_EXP_W     8
`define FPMUL_MAN_W     23
`define FPMUL_SIG_W     24
`define FPMUL_BIAS      127

// Karatsuba recursion stops at this operand width
`define FPMUL_KOA_LEAF  7

// Derived widths, exponent sum keeps two guard bits and a sign
`define FPMUL_EXPSUM_W  (`FPMUL_EXP_W + 2)
`define FPMUL_PROD_W    (2 * `FPMUL_SIG_W)

`endif

//--- logic/fpFormatPkg.sv
// Floating-point format types shared by the multiply pipeline
// Packed IEEE word as seen on the ports, and the unpacked operand pair
`include "fpmul_consts.svh"

package fpFormatPkg;

    //============================================================
    // IEEE-754 single-precision word
    //============================================================
    // Field order matches the bit layout, sign in bit 31
    typedef struct packed {
        logic                      sign;
        logic [`FPMUL_EXP_W-1:0]   exponent;
        logic [`FPMUL_MAN_W-1:0]   mantissa;
    } floatWord_t;

    //============================================================
    // Operand pair after unpacking
    //============================================================
    // Biased exponent sum with bias already removed once
    // Two extra bits hold overflow and sign of the sum
    // Significands carry the restored hidden bit at the top
    typedef struct packed {
        logic                                sign;
        logic signed [`FPMUL_EXPSUM_W-1:0]   expSum;
        logic [`FPMUL_SIG_W-1:0]             sigA;
        logic [`FPMUL_SIG_W-1:0]             sigB;
    } unpackedOp_t;

endpackage

//--- logic/fpMulTop.sv
// Top level of the single-precision multiply unit
// Three-stage pipeline, fixed three-cycle latency, one item per cycle
`timescale 1ns/100ps

module fpMulTop (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     opValid_i,
    input  fpFormatPkg::floatWord_t  opA_i,
    input  fpFormatPkg::floatWord_t  opB_i,
    input  mulPipePkg::roundOp_e     roundOp_i,
    output logic                     resValid_o,
    output fpFormatPkg::floatWord_t  result_o
);
    import mulPipePkg::*;

    unpackStage_t   unpackStage;
    productStage_t  productStage;

    // Producer, registers and unpacks the operand pair
    operandUnpack uUnpack (
        .clk       (clk),
        .reset_i   (reset_i),
        .opValid_i (opValid_i),
        .opA_i     (opA_i),
        .opB_i     (opB_i),
        .roundOp_i (roundOp_i),
        .stage_o   (unpackStage)
    );

    // Karatsuba significand product
    significandMul uMul (
        .clk     (clk),
        .reset_i (reset_i),
        .stage_i (unpackStage),
        .stage_o (productStage)
    );

    // Normalize, round and drive the result port
    productRound uRound (
        .clk        (clk),
        .reset_i    (reset_i),
        .stage_i    (productStage),
        .resValid_o (resValid_o),
        .result_o   (result_o)
    );

endmodule

//--- logic/karatsubaCore.sv
// Combinational recursive Karatsuba multiplier for unsigned operands
// Splits each operand into halves, forms three smaller products and
// recombines them; falls back to a direct product at the leaf width
`timescale 1ns/100ps
`include "fpmul_consts.svh"

module karatsubaCore #(
    parameter int SW = 24
) (
    input  logic [SW-1:0]    dataA_i,
    input  logic [SW-1:0]    dataB_i,
    output logic [2*SW-1:0]  product_o
);

    generate
        if (SW <= `FPMUL_KOA_LEAF) begin : gLeaf
            // Small enough for a plain array multiplier
            assign product_o = (2*SW)'(dataA_i) * (2*SW)'(dataB_i);
        end else begin : gSplit
            //====================================================
            // Operand split
            //====================================================
            // High half takes the floor, low half the ceiling,
            // so odd widths put the extra bit in the low half
            localparam int HW = SW / 2;
            localparam int LW = SW - HW;
            // Half-sums need one carry bit
            localparam int MW = LW + 1;
            localparam int PW = 2 * MW;

            logic [MW-1:0]     sumA;
            logic [MW-1:0]     sumB;
            logic [2*HW-1:0]   prodHigh;
            logic [2*LW-1:0]   prodLow;
            logic [PW-1:0]     prodSum;
            logic [PW-1:0]     midTerm;

            assign sumA = MW'(dataA_i[SW-1:LW]) + MW'(dataA_i[LW-1:0]);
            assign sumB = MW'(dataB_i[SW-1:LW]) + MW'(dataB_i[LW-1:0]);

            //====================================================
            // Three sub-products
            //====================================================
            karatsubaCore #(.SW(HW)) uHigh (
                .dataA_i   (dataA_i[SW-1:LW]),
                .dataB_i   (dataB_i[SW-1:LW]),
                .product_o (prodHigh)
            );

            karatsubaCore #(.SW(LW)) uLow (
                .dataA_i   (dataA_i[LW-1:0]),
                .dataB_i   (dataB_i[LW-1:0]),
                .product_o (prodLow)
            );

            karatsubaCore #(.SW(MW)) uSum (
                .dataA_i   (sumA),
                .dataB_i   (sumB),
                .product_o (prodSum)
            );

            // Cross terms aH*bL + aL*bH, never negative
            assign midTerm = prodSum - PW'(prodHigh) - PW'(prodLow);

            //====================================================
            // Recombine
            //====================================================
            // Concatenation places high product at 2*LW directly
            assign product_o = {prodHigh, prodLow} + ((2*SW)'(midTerm) << LW);
        end
    endgenerate

endmodule

//--- logic/mulPipePkg.sv
// Pipeline types of the multiply unit
// Rounding opcode and the packed payload carried between stages
`include "fpmul_consts.svh"

package mulPipePkg;

    // Rounding opcode travels with every item
    typedef enum logic {
        RND_NEAREST_EVEN = 1'b0,
        RND_TRUNCATE     = 1'b1
    } roundOp_e;

    //============================================================
    // Stage payloads
    //============================================================
    // Unpacker to significand multiplier
    typedef struct packed {
        logic                      valid;
        roundOp_e                  roundOp;
        fpFormatPkg::unpackedOp_t  op;
    } unpackStage_t;

    // Significand multiplier to rounder
    // Product is the full 48-bit significand product
    typedef struct packed {
        logic                                valid;
        roundOp_e                            roundOp;
        logic                                sign;
        logic signed [`FPMUL_EXPSUM_W-1:0]   exponent;
        logic [`FPMUL_PROD_W-1:0]            product;
    } productStage_t;

endpackage

//--- logic/operandUnpack.sv
// First pipeline stage of the multiplier
// Registers the operand pair with its opcode, restores hidden bits,
// forms the result sign and the unbiased exponent sum
`timescale 1ns/100ps
`include "fpmul_consts.svh"

module operandUnpack (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      opValid_i,
    input  fpFormatPkg::floatWord_t   opA_i,
    input  fpFormatPkg::floatWord_t   opB_i,
    input  mulPipePkg::roundOp_e      roundOp_i,
    output mulPipePkg::unpackStage_t  stage_o
);
    import fpFormatPkg::*;
    import mulPipePkg::*;

    localparam int EW = `FPMUL_EXPSUM_W;
    localparam logic [EW-1:0] BIAS_EXT = EW'(`FPMUL_BIAS);

    unpackedOp_t unpackNext;

    //============================================================
    // Unpack
    //============================================================
    always_comb begin
        unpackNext.sign   = opA_i.sign ^ opB_i.sign;
        // Zero-extend both fields before the add so the carry survives
        unpackNext.expSum = EW'(opA_i.exponent) + EW'(opB_i.exponent) - BIAS_EXT;
        // Hidden 1 in front of each stored mantissa
        unpackNext.sigA   = {1'b1, opA_i.mantissa};
        unpackNext.sigB   = {1'b1, opB_i.mantissa};
    end

    //============================================================
    // Stage register
    //============================================================
    // Valid follows the input every cycle, payload only on a strobe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            stage_o <= '0;
        end else begin
            stage_o.valid <= opValid_i;
            if (opValid_i) begin
                stage_o.roundOp <= roundOp_i;
                stage_o.op      <= unpackNext;
            end
        end
    end

    // Only normal operands enter the pipe
    assert property (@(posedge clk) disable iff (reset_i)
        opValid_i |-> (opA_i.exponent != '0) && (opA_i.exponent != '1) &&
                      (opB_i.exponent != '0) && (opB_i.exponent != '1))
        else $error("operand with zero or all-ones exponent field");

endmodule

//--- logic/productRound.sv
// Last pipeline stage of the multiplier
// Normalizes the product by at most one place, rounds by opcode,
// packs the IEEE word and registers it with the result strobe
`timescale 1ns/100ps
`include "fpmul_consts.svh"

module productRound (
    input  logic                       clk,
    input  logic                       reset_i,
    input  mulPipePkg::productStage_t  stage_i,
    output logic                       resValid_o,
    output fpFormatPkg::floatWord_t    result_o
);
    import fpFormatPkg::*;
    import mulPipePkg::*;

    localparam int EW = `FPMUL_EXPSUM_W;
    localparam int MW = `FPMUL_MAN_W;
    localparam int PW = `FPMUL_PROD_W;

    logic [MW-1:0]         manWindow;
    logic                  guardBit;
    logic                  stickyBit;
    logic                  roundUp;
    logic [MW:0]           manRounded;
    logic signed [EW-1:0]  expNorm;
    logic signed [EW-1:0]  expAdj;
    floatWord_t            resultNext;

    //============================================================
    // Normalize, round, pack
    //============================================================
    always_comb begin
        // Product in [2,4) shifts right by one
        if (stage_i.product[PW-1]) begin
            manWindow = stage_i.product[PW-2 -: MW];
            guardBit  = stage_i.product[PW-2-MW];
            stickyBit = |stage_i.product[PW-3-MW:0];
            expNorm   = stage_i.exponent + EW'(1);
        end else begin
            manWindow = stage_i.product[PW-3 -: MW];
            guardBit  = stage_i.product[PW-3-MW];
            stickyBit = |stage_i.product[PW-4-MW:0];
            expNorm   = stage_i.exponent;
        end

        // Ties go to the even mantissa
        roundUp = (stage_i.roundOp == RND_NEAREST_EVEN) && guardBit &&
                  (stickyBit || manWindow[0]);

        // Extra top bit catches the carry out of the mantissa
        manRounded = {1'b0, manWindow} + (MW+1)'(roundUp);
        expAdj     = expNorm + EW'(manRounded[MW]);

        // On carry the low bits are already zero
        resultNext.sign     = stage_i.sign;
        resultNext.exponent = expAdj[`FPMUL_EXP_W-1:0];
        resultNext.mantissa = manRounded[MW-1:0];
    end

    //============================================================
    // Output register
    //============================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            resValid_o <= 1'b0;
            result_o   <= '0;
        end else begin
            resValid_o <= stage_i.valid;
            if (stage_i.valid) begin
                result_o <= resultNext;
            end
        end
    end

    // Final exponent must land in the normal range
    assert property (@(posedge clk) disable iff (reset_i)
        stage_i.valid |-> (expAdj > 0) && (expAdj < 255))
        else $error("result exponent out of normal range");

endmodule

//--- logic/significandMul.sv
// Second pipeline stage of the multiplier
// Multiplies the two significands through the Karatsuba core and
// registers the 48-bit product with sign, exponent and opcode
`timescale 1ns/100ps
`include "fpmul_consts.svh"

module significandMul (
    input  logic                       clk,
    input  logic                       reset_i,
    input  mulPipePkg::unpackStage_t   stage_i,
    output mulPipePkg::productStage_t  stage_o
);
    import mulPipePkg::*;

    logic [`FPMUL_PROD_W-1:0] product;

    // Full-width significand product, one clock of combinational depth
    karatsubaCore #(.SW(`FPMUL_SIG_W)) uKoa (
        .dataA_i   (stage_i.op.sigA),
        .dataB_i   (stage_i.op.sigB),
        .product_o (product)
    );

    //============================================================
    // Stage register
    //============================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            stage_o <= '0;
        end else begin
            stage_o.valid <= stage_i.valid;
            // Hold payload across idle cycles
            if (stage_i.valid) begin
                stage_o.roundOp  <= stage_i.roundOp;
                stage_o.sign     <= stage_i.op.sign;
                stage_o.exponent <= stage_i.op.expSum;
                stage_o.product  <= product;
            end
        end
    end

    // Two significands in [1,2) give a product in [1,4)
    // so one of the top two bits must be set
    assert property (@(posedge clk) disable iff (reset_i)
        stage_o.valid |-> (stage_o.product[`FPMUL_PROD_W-1] ||
                           stage_o.product[`FPMUL_PROD_W-2]))
        else $error("significand product below 1.0");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the multiply pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module fpMulTb \
    -o fpMulSim

# A failing run still has to reach the log check below
./obj_dir/fpMulSim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

//--- tb/fpMulTb.sv
// Directed testbench of the single-precision multiply pipeline
// Drives operand pairs, keeps a queue of expected words with their due
// cycle and checks every cycle of resValid_o and result_o against it
`timescale 1ns/100ps

module fpMulTb;
    import fpFormatPkg::*;
    import mulPipePkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int LATENCY      = 3;
    localparam int DRIVE_DELAY  = 2;
    localparam int STREAM_ITEMS = 200;
    localparam int GAP_ITEMS    = 100;
    // Directed tests fit in 200 cycles and a gapped item takes up to four
    localparam int TEST_CYCLES  = 200 + STREAM_ITEMS + 4 * GAP_ITEMS;
    localparam int MARGIN_NS    = 2000;

    logic        clk;
    logic        reset;
    logic        opValid;
    floatWord_t  opA;
    floatWord_t  opB;
    roundOp_e    roundOp;
    logic        resValid;
    floatWord_t  result;

    integer      seed;
    int          cycleCount = 0;
    // Expected words and the cycle each one must show up in
    logic [31:0] expWordQ[$];
    int          dueQ[$];

    tbClockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) uClkGen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    fpMulTop dut (
        .clk        (clk),
        .reset_i    (reset),
        .opValid_i  (opValid),
        .opA_i      (opA),
        .opB_i      (opB),
        .roundOp_i  (roundOp),
        .resValid_o (resValid),
        .result_o   (result)
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    //============================================================
    // Reference model of the multiply rule
    //============================================================
    function automatic logic [31:0] refMul(input logic [31:0] a, input logic [31:0] b,
                                           input roundOp_e rnd);
        logic [47:0] p;
        int          e;
        logic        sign;
        logic [22:0] man;
        logic        guard;
        logic        sticky;
        logic [23:0] manR;
        p    = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
        e    = int'(a[30:23]) + int'(b[30:23]) - 127;
        sign = a[31] ^ b[31];
        // Product in [2,4) takes the upper window
        if (p[47]) begin
            man    = p[46:24];
            guard  = p[23];
            sticky = |p[22:0];
            e      = e + 1;
        end else begin
            man    = p[45:23];
            guard  = p[22];
            sticky = |p[21:0];
        end
        manR = {1'b0, man};
        if (rnd == RND_NEAREST_EVEN && guard && (sticky || man[0])) begin
            manR = manR + 24'd1;
        end
        // Carry out leaves the low 23 bits at zero
        if (manR[23]) begin
            e = e + 1;
        end
        return {sign, e[7:0], manR[22:0]};
    endfunction

    // Normal operand with exponent field 64..190
    function automatic logic [31:0] randomOperand();
        logic [31:0] r;
        logic [31:0] m;
        logic [31:0] e;
        r = $random(seed);
        m = $random(seed);
        e = 32'd64 + ({1'b0, r[30:0]} % 32'd127);
        return {m[31], e[7:0], m[22:0]};
    endfunction

    //============================================================
    // Compare and drive helpers
    //============================================================
    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Strobe launched after this edge is due LATENCY edges later
    task automatic sendOp(input logic [31:0] a, input logic [31:0] b,
                          input roundOp_e rnd, input logic [31:0] expected);
        @(posedge clk);
        #DRIVE_DELAY;
        opValid = 1'b1;
        opA     = a;
        opB     = b;
        roundOp = rnd;
        expWordQ.push_back(expected);
        dueQ.push_back(cycleCount + LATENCY);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
            opValid = 1'b0;
        end
    endtask

    // Bounded wait until every pending result has been seen
    task automatic waitDrain();
        int waited;
        waited = 0;
        while (dueQ.size() != 0 && waited <= LATENCY + 4) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
        end
        if (dueQ.size() != 0) begin
            $display("Pipeline never delivered %0d pending results", dueQ.size());
            $display("sim failed");
            $fatal(1, "drain timeout");
        end
    endtask

    task automatic checkOne(input logic [31:0] a, input logic [31:0] b,
                            input roundOp_e rnd, input logic [31:0] expected);
        sendOp(a, b, rnd, expected);
        idleCycles(1);
        waitDrain();
    endtask

    task automatic checkBothModes(input logic [31:0] a, input logic [31:0] b,
                                  input logic [31:0] expected);
        checkOne(a, b, RND_NEAREST_EVEN, expected);
        checkOne(a, b, RND_TRUNCATE, expected);
    endtask

    //============================================================
    // Result monitor
    //============================================================
    // Valid must be high exactly on the due cycle
    // Sampled on the falling edge where outputs are stable
    always @(negedge clk) begin : resultMonitor
        logic dueNow;
        if (reset === 1'b0) begin
            dueNow = (dueQ.size() != 0) && (dueQ[0] == cycleCount);
            checkValue("resValid_o", 32'(resValid), 32'(dueNow));
            if (dueNow) begin
                checkValue("result_o", result, expWordQ[0]);
                expWordQ.delete(0);
                dueQ.delete(0);
            end
        end
    end

    //============================================================
    // Tests
    //============================================================
    // Quiet after reset then a single strobe and quiet again
    task automatic testResetIdle();
        idleCycles(6);
        sendOp(32'h3F800000, 32'h3F800000, RND_NEAREST_EVEN, 32'h3F800000);
        idleCycles(8);
        waitDrain();
    endtask

    task automatic testExact();
        checkBothModes(32'h3F800000, 32'h3F800000, 32'h3F800000);
        checkBothModes(32'h40000000, 32'h40400000, 32'h40C00000);
        checkBothModes(32'hBFC00000, 32'h40800000, 32'hC0C00000);
        // Two negatives give a positive
        checkBothModes(32'hC0000000, 32'hC0400000, 32'h40C00000);
    endtask

    // Significand product of 2.25 bumps the exponent
    task automatic testNormalize();
        checkBothModes(32'h3FC00000, 32'h3FC00000, 32'h40100000);
        checkBothModes(32'h40400000, 32'h40400000, 32'h41100000);
    endtask

    task automatic testRounding();
        // Tie on even LSB stays unchanged
        checkBothModes(32'h3F800003, 32'h3FC00000, 32'h3FC00004);
        // Tie on odd LSB
        checkOne(32'h3F800001, 32'h3FC00000, RND_NEAREST_EVEN, 32'h3FC00002);
        checkOne(32'h3F800001, 32'h3FC00000, RND_TRUNCATE, 32'h3FC00001);
        // Remainder above half an ulp
        checkOne(32'h3F800800, 32'h3F800802, RND_NEAREST_EVEN, 32'h3F801003);
        checkOne(32'h3F800800, 32'h3F800802, RND_TRUNCATE, 32'h3F801002);
        // 2 - 2^-45 rounds up to 2.0 through the carry
        checkOne(32'h3F800001, 32'h3FFFFFFE, RND_NEAREST_EVEN, 32'h40000000);
        checkOne(32'h3F800001, 32'h3FFFFFFE, RND_TRUNCATE, 32'h3FFFFFFF);
    endtask

    // One pair per cycle with no idle in between
    task automatic testStream();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        roundOp_e    rnd;
        for (int i = 0; i < STREAM_ITEMS; i++) begin
            a   = randomOperand();
            b   = randomOperand();
            r   = $random(seed);
            rnd = roundOp_e'(r[0]);
            sendOp(a, b, rnd, refMul(a, b, rnd));
        end
        idleCycles(1);
        waitDrain();
    endtask

    // Random idle gaps of up to three cycles
    task automatic testGaps();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        roundOp_e    rnd;
        for (int i = 0; i < GAP_ITEMS; i++) begin
            a   = randomOperand();
            b   = randomOperand();
            r   = $random(seed);
            rnd = roundOp_e'(r[0]);
            sendOp(a, b, rnd, refMul(a, b, rnd));
            idleCycles(int'(r[2:1]));
        end
        idleCycles(1);
        waitDrain();
    endtask

    //============================================================
    // Main sequence and watchdog
    //============================================================
    initial begin : mainSequence
        opValid = 1'b0;
        opA     = '0;
        opB     = '0;
        roundOp = RND_NEAREST_EVEN;
        seed    = 32'h285bccd6;
        wait (reset === 1'b0);
        testResetIdle();
        testExact();
        testNormalize();
        testRounding();
        testStream();
        testGaps();
        $display("sim passed");
        $finish;
    end

    initial begin : watchdog
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Watchdog expired before the tests finished");
        $display("sim failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- tb/tbClockGen.sv
// Clock and reset source for the multiplier testbench
// Free-running clock, reset held high over the first rising edges
`timescale 1ns/100ps

module tbClockGen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    // Clock starts low, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release 2 ns after an edge, same as the other stimulus
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        reset_o = 1'b0;
    end

endmodule
